// ==== dv/adpcm_assertions.sv ====
`timescale 1ns/1ps
`include "adpcm_defs.svh"

module adpcm_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      cen,
    input logic                      seq_gnt,
    input logic                      host_gnt,
    input logic                      host_busy,
    input adpcm_pkg::ch_t            pcm_ch,
    input adpcm_pkg::fetch_state_e   fetch_state
);

    import adpcm_pkg::*;

    localparam ch_t LAST_CH = ch_t'(`ADPCM_NUM_CH - 1);

    logic [3:0] busy_cycles; // Consecutive cycles with host_busy high

    function automatic ch_t slot_after(input ch_t s);
        return (s == LAST_CH) ? ch_t'(0) : ch_t'(s + 1'b1);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) busy_cycles <= '0;
        else if (host_busy) busy_cycles <= busy_cycles + 1'b1;
        else busy_cycles <= '0;
    end

    // Only one master owns the RAM per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(seq_gnt && host_gnt))
        else $error("Arbiter granted both masters in one cycle");

    // Slot shown on pcm steps round 0 to 5
    a_slot_step: assert property (@(posedge clk) disable iff (!rst_n)
        cen |=> (pcm_ch == slot_after($past(pcm_ch))))
        else $error("pcm_ch did not advance by one at cen");

    a_busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        busy_cycles < 4'd8)
        else $error("host_busy stayed high for 8 cycles");

    // Byte prefetch must be over when the slot comes
    a_fetch_done: assert property (@(posedge clk) disable iff (!rst_n)
        cen |-> (fetch_state == FETCH_IDLE))
        else $error("Sequencer fetch still running at cen");

endmodule

bind adpcm_top adpcm_assertions u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .cen         (cen),
    .seq_gnt     (seq_bus.gnt),
    .host_gnt    (host_bus.gnt),
    .host_busy   (host_busy),
    .pcm_ch      (pcm_ch),
    .fetch_state (u_seq.fstate)
);

// ==== dv/adpcm_tb.sv ====
`timescale 1ns/1ps
`include "adpcm_defs.svh"

module adpcm_tb;

    import adpcm_pkg::*;

    localparam int NUM_CH     = `ADPCM_NUM_CH;
    localparam int CEN_LIMIT  = 20;  // Clocks allowed between cens
    localparam int BUSY_LIMIT = 20;  // Clocks allowed for one host write
    localparam int IDLE_LIMIT = 500; // Cens allowed for a channel to finish

    logic                           clk;
    logic                           rst_n;
    logic                           cen;
    logic                           host_we;
    addr_t                          host_addr;
    logic [7:0]                     host_wdata;
    logic                           host_busy;
    logic                           key_on;
    logic                           key_off;
    ch_t                            key_ch;
    addr_t                          key_start;
    addr_t                          key_end;
    logic [NUM_CH-1:0]              ch_active;
    logic signed [`ADPCM_PCM_W-1:0] pcm;
    ch_t                            pcm_ch;

    // Model of RAM contents and per-channel playback
    logic [7:0]        model_mem [1 << `ADPCM_ADDR_W];
    logic [15:0]       model_val [NUM_CH];
    logic [15:0]       model_step [NUM_CH];
    int                model_addr [NUM_CH];
    int                model_end [NUM_CH];
    logic [NUM_CH-1:0] model_active;
    logic [NUM_CH-1:0] model_phase;   // Low nibble next
    int                exp_slot;

    logic [31:0] lfsr_state;
    int          err_count;
    int          test_err_base;
    int          passed_tests;
    int          failed_tests;
    logic        timed_out;

    adpcm_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen        (cen),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_busy  (host_busy),
        .key_on     (key_on),
        .key_off    (key_off),
        .key_ch     (key_ch),
        .key_start  (key_start),
        .key_end    (key_end),
        .ch_active  (ch_active),
        .pcm        (pcm),
        .pcm_ch     (pcm_ch)
    );

    always #5 clk = ~clk; // 10 ns period

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        int         i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]}; // One bit per step
        end
        return b;
    endfunction

    // One decoder update returning {value, step}
    function automatic logic [31:0] adpcm_ref_step(input logic [3:0] nib, input logic [15:0] val,
                                                   input logic [15:0] step);
        int          mag;
        int          delta;
        int          factor;
        int          nstep;
        logic [15:0] sum;
        mag   = 2 * int'(nib[2:0]) + 1;  // LSB forced to 1
        delta = (mag * int'(step)) / 8;
        sum   = val + (nib[3] ? 16'(-delta) : 16'(delta)); // 16-bit sum
        // Signed overflow only when delta and value share a sign
        if ((nib[3] == val[15]) && (sum[15] != nib[3])) begin
            sum = nib[3] ? 16'h8000 : 16'h7fff;
        end
        case (nib[2:0])
            3'd4:    factor = 77;
            3'd5:    factor = 102;
            3'd6:    factor = 128;
            3'd7:    factor = 153;
            default: factor = 57;
        endcase
        nstep = (int'(step) * factor) / 64;
        if (nstep < `ADPCM_STEP_MIN) nstep = `ADPCM_STEP_MIN;
        else if (nstep > `ADPCM_STEP_MAX) nstep = `ADPCM_STEP_MAX;
        return {sum, 16'(nstep)};
    endfunction

    task automatic finish_run();
        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 passed_tests, failed_tests, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: no %s in time", $time, what);
        timed_out = 1'b1;
        finish_run();
    endtask

    task automatic report_test(input string name);
        int n;
        n = err_count - test_err_base;
        if (n == 0) begin
            passed_tests++;
            $display("Test %s: passed", name);
        end else begin
            failed_tests++;
            $display("Test %s: %0d errors", name, n);
        end
        test_err_base = err_count;
    endtask

    // Returns at the clock edge that samples cen high
    task automatic wait_cen();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cen && n < CEN_LIMIT);
        if (!cen) abort_on_timeout("cen pulse");
    endtask

    task automatic wait_cens(input int count);
        int i;
        for (i = 0; i < count; i++) wait_cen();
        #3; // Past the slot compare
    endtask

    task automatic wait_channel_idle(input int ch);
        int n;
        n = 0;
        while (ch_active[ch] && n < IDLE_LIMIT) begin
            wait_cen();
            #2;
            n++;
        end
        if (ch_active[ch]) abort_on_timeout("end of channel playback");
    endtask

    task automatic load_byte(input int addr, input logic [7:0] val);
        int n;
        @(posedge clk);
        #1;
        host_we    = 1'b1;
        host_addr  = addr_t'(addr);
        host_wdata = val;
        model_mem[addr] = val;
        @(posedge clk);
        #1;
        host_we = 1'b0;
        assert (host_busy) else begin
            $display("ERROR %0t: host_busy low after an accepted write", $time);
            err_count++;
        end
        n = 0;
        while (host_busy && n < BUSY_LIMIT) begin // Wait for the grant
            @(posedge clk);
            #1;
            n++;
        end
        if (host_busy) abort_on_timeout("fall of host_busy");
    endtask

    // Key strobes go out one cycle after a cen
    task automatic key_command(input logic on, input int ch, input int first, input int last);
        wait_cen();
        #1;
        key_on    = on;
        key_off   = !on;
        key_ch    = ch_t'(ch);
        key_start = addr_t'(first);
        key_end   = addr_t'(last);
        #2; // Model follows once the shown slot is compared
        if (on) begin
            model_active[ch] = 1'b1;
            model_phase[ch]  = 1'b0; // High nibble first
            model_addr[ch]   = first;
            model_end[ch]    = last;
        end else begin
            model_active[ch] = 1'b0;
        end
        @(posedge clk);
        #1;
        key_on  = 1'b0;
        key_off = 1'b0;
    endtask

    // Compare the slot shown after each cen and advance its model
    always @(posedge clk) begin : compare_slots
        logic [3:0]  nib;
        logic [31:0] nxt;
        int          s;
        if (rst_n && cen) begin
            #2;
            s = exp_slot;
            assert (pcm_ch == ch_t'(s)) else begin
                $display("ERROR %0t: pcm_ch %0d, expected %0d", $time, pcm_ch, s);
                err_count++;
            end
            assert (pcm == model_val[s]) else begin
                $display("ERROR %0t: slot %0d pcm %0d, expected %0d", $time, s, pcm,
                         $signed(model_val[s]));
                err_count++;
            end
            if (model_active[s]) begin
                nib = model_phase[s] ? model_mem[model_addr[s]][3:0]
                                     : model_mem[model_addr[s]][7:4];
                nxt = adpcm_ref_step(nib, model_val[s], model_step[s]);
                model_val[s]  = nxt[31:16];
                model_step[s] = nxt[15:0];
                if (model_phase[s]) begin
                    if (model_addr[s] == model_end[s]) model_active[s] = 1'b0; // Retired
                    else model_addr[s]++;
                end
                model_phase[s] = !model_phase[s];
            end else begin
                model_val[s]  = '0; // Idle slot resets the state
                model_step[s] = 16'(`ADPCM_STEP_MIN);
            end
            exp_slot = (s == NUM_CH - 1) ? 0 : s + 1;
            assert (ch_active == model_active) else begin
                $display("ERROR %0t: ch_active %b, expected %b", $time, ch_active, model_active);
                err_count++;
            end
        end
    end

    // cen every 5 clocks once reset is over
    initial begin
        cen = 1'b0;
        repeat (10) @(posedge clk);
        forever begin
            repeat (4) @(posedge clk);
            #1;
            cen = 1'b1;
            @(posedge clk);
            #1;
            cen = 1'b0;
        end
    end

    initial begin
        logic [7:0] b;
        int         i;
        int         c;
        int         base;
        int         len;
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        key_on     = 1'b0;
        key_off    = 1'b0;
        key_ch     = '0;
        key_start  = '0;
        key_end    = '0;
        lfsr_state    = 32'hf503;
        err_count     = 0;
        test_err_base = 0;
        passed_tests  = 0;
        failed_tests  = 0;
        timed_out     = 1'b0;
        exp_slot      = 0;
        model_active  = '0;
        model_phase   = '0;
        for (c = 0; c < NUM_CH; c++) begin
            model_val[c]  = '0;
            model_step[c] = 16'(`ADPCM_STEP_MIN);
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle slots after reset
        wait_cens(12);
        assert (ch_active == '0) else begin
            $display("ERROR %0t: ch_active %b after reset", $time, ch_active);
            err_count++;
        end
        report_test("1 idle slots");

        // One channel over 32 random bytes
        for (i = 0; i < 32; i++) load_byte(i, random_byte());
        key_command(1'b1, 2, 0, 31);
        wait_channel_idle(2);
        wait_cens(7);
        report_test("2 single channel");

        // Six regions where channel 0 saturates high and channel 3 low
        for (c = 0; c < NUM_CH; c++) begin
            base = 64 + 32 * c;
            len  = 6 + 2 * c;
            for (i = 0; i < len; i++) begin
                if (c == 0) b = (i < 3) ? 8'h77 : 8'h44;
                else if (c == 3) b = (i < 3) ? 8'hff : 8'hcc;
                else b = random_byte();
                load_byte(base + i, b);
            end
        end
        for (c = 0; c < NUM_CH; c++) key_command(1'b1, c, 64 + 32 * c, 64 + 32 * c + 5 + 2 * c);
        wait_cens(30);
        report_test("3 six channels");

        // Shortest region ends first
        wait_channel_idle(0);
        assert (ch_active[5:1] == 5'h1f) else begin
            $display("ERROR %0t: ch_active %b when channel 0 ended", $time, ch_active);
            err_count++;
        end
        wait_cens(7);
        report_test("4 end of region");

        // Host writes to spare space while playback runs
        for (i = 0; i < 16; i++) load_byte(768 + i, random_byte());
        for (i = 0; i < 16; i++) begin
            assert (dut0.u_ram.mem[768 + i] == model_mem[768 + i]) else begin
                $display("ERROR %0t: RAM byte %0d is %h, expected %h", $time, 768 + i,
                         dut0.u_ram.mem[768 + i], model_mem[768 + i]);
                err_count++;
            end
        end
        report_test("5 host writes during playback");

        // Stop the longest channel early
        key_command(1'b0, 5, 0, 0);
        wait_cens(7);
        assert (!ch_active[5]) else begin
            $display("ERROR %0t: channel 5 still active after key_off", $time);
            err_count++;
        end
        for (c = 0; c < NUM_CH; c++) wait_channel_idle(c);
        wait_cens(7);
        report_test("6 key off");

        finish_run();
    end

endmodule

// ==== include/adpcm_defs.svh ====
`ifndef ADPCM_DEFS_SVH
`define ADPCM_DEFS_SVH

// Channel count, equal to the decoder loop depth
`define ADPCM_NUM_CH 6

// Sample RAM byte address width (1024 bytes)
`define ADPCM_ADDR_W 10

// Decoded PCM sample width
`define ADPCM_PCM_W 16

// Step size clamp limits, the step also resets to the minimum
`define ADPCM_STEP_MIN 127
`define ADPCM_STEP_MAX 24576

`endif

// ==== logic/adpcm_decode.sv ====
`timescale 1ns/1ps
`include "adpcm_defs.svh"

module adpcm_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cen,   // One pipeline step per strobe
    input  logic [3:0]                     data,  // Sign and 3-bit magnitude
    input  logic                           chon,  // Slot's channel is playing
    output logic signed [`ADPCM_PCM_W-1:0] pcm
);

    localparam int PCM_W  = `ADPCM_PCM_W;
    localparam int STEP_W = $clog2(`ADPCM_STEP_MAX + 1); // 15 bits

    localparam logic signed [PCM_W-1:0] PCM_MAX = {1'b0, {(PCM_W-1){1'b1}}};
    localparam logic signed [PCM_W-1:0] PCM_MIN = {1'b1, {(PCM_W-1){1'b0}}};
    localparam logic [STEP_W-1:0] STEP_LO = STEP_W'(`ADPCM_STEP_MIN);
    localparam logic [STEP_W-1:0] STEP_HI = STEP_W'(`ADPCM_STEP_MAX);

    // Values per stage with six channels in flight
    logic signed [PCM_W-1:0] x1, x2, x3, x4, x5, x6;
    logic [STEP_W-1:0]       step1, step2, step6;
    logic [STEP_W+1:0]       step3, step4, step5; // Unclamped 17-bit step
    logic [3:0]              d2;
    logic [PCM_W-1:0]        d3, d4;
    logic                    sign2, sign3, sign4, sign5;
    logic                    chon2, chon3, chon4, chon5;
    logic                    sign_equ4, sign_equ5; // Delta sign matches value sign
    logic [7:0]              step_val;
    logic [STEP_W+3:0]       d2l;
    logic [STEP_W+7:0]       step2l;

    assign pcm = x2; // State before this slot's nibble

    // Stage II multipliers
    always_comb begin
        if (!d2[3]) begin
            step_val = 8'd57; // Small magnitude shrinks the step
        end else begin
            case (d2[2:1])
                2'b00:   step_val = 8'd77;
                2'b01:   step_val = 8'd102;
                2'b10:   step_val = 8'd128;
                default: step_val = 8'd153;
            endcase
        end
        d2l    = d2 * step2;       // Magnitude times step before the /8
        step2l = step_val * step2; // /64 taken below
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1 <= '0;
            x2 <= '0;
            x3 <= '0;
            x4 <= '0;
            x5 <= '0;
            x6 <= '0;
            step1 <= STEP_LO;
            step2 <= STEP_LO;
            step3 <= (STEP_W+2)'(`ADPCM_STEP_MIN);
            step4 <= (STEP_W+2)'(`ADPCM_STEP_MIN);
            step5 <= (STEP_W+2)'(`ADPCM_STEP_MIN);
            step6 <= STEP_LO;
            d2 <= '0;
            d3 <= '0;
            d4 <= '0;
            sign2 <= 1'b0;
            sign3 <= 1'b0;
            sign4 <= 1'b0;
            sign5 <= 1'b0;
            chon2 <= 1'b0;
            chon3 <= 1'b0;
            chon4 <= 1'b0;
            chon5 <= 1'b0;
            sign_equ4 <= 1'b0;
            sign_equ5 <= 1'b0;
        end else if (cen) begin
            // I  magnitude with LSB forced and sign split
            d2    <= {data[2:0], 1'b1};
            sign2 <= data[3];
            x2    <= x1;
            step2 <= step1;
            chon2 <= chon;
            // II  delta and next step
            d3    <= d2l[PCM_W+2:3];
            sign3 <= sign2;
            x3    <= x2;
            step3 <= step2l[STEP_W+7:6];
            chon3 <= chon2;
            // III  negate delta
            d4        <= sign3 ? ~d3 + 1'b1 : d3;
            sign4     <= sign3;
            sign_equ4 <= (sign3 == x3[PCM_W-1]);
            x4        <= x3;
            step4     <= step3;
            chon4     <= chon3;
            // IV  sum
            x5        <= x4 + $signed(d4);
            sign5     <= sign4;
            sign_equ5 <= sign_equ4;
            step5     <= step4;
            chon5     <= chon4;
            // V  saturate and clamp or reset an idle slot
            if (chon5) begin
                if (sign_equ5 && (sign5 != x5[PCM_W-1])) x6 <= sign5 ? PCM_MIN : PCM_MAX;
                else x6 <= x5;
                if (step5 < `ADPCM_STEP_MIN) step6 <= STEP_LO;
                else if (step5 > `ADPCM_STEP_MAX) step6 <= STEP_HI;
                else step6 <= step5[STEP_W-1:0];
            end else begin
                x6    <= '0;
                step6 <= STEP_LO;
            end
            // VI  back round the loop
            x1    <= x6;
            step1 <= step6;
        end
    end

endmodule

// ==== logic/adpcm_pkg.sv ====
`include "adpcm_defs.svh"

package adpcm_pkg;

    // Channel or slot index, 0 to 5
    typedef logic [2:0] ch_t;

    // Byte address into the sample RAM
    typedef logic [`ADPCM_ADDR_W-1:0] addr_t;

    // Master holding the RAM in the current cycle
    typedef enum logic [1:0] {
        OWNER_NONE = 2'd0,
        OWNER_SEQ  = 2'd1, // Channel sequencer, highest priority
        OWNER_HOST = 2'd2  // Host loader
    } arb_owner_e;

    // Sequencer byte fetch FSM
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_REQ  = 2'd1, // Request held until granted
        FETCH_WAIT = 2'd2  // Read data returns this cycle
    } fetch_state_e;

endpackage

// ==== logic/adpcm_top.sv ====
`timescale 1ns/1ps
`include "adpcm_defs.svh"

module adpcm_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cen,
    // Host byte loader
    input  logic                           host_we,
    input  adpcm_pkg::addr_t               host_addr,
    input  logic [7:0]                     host_wdata,
    output logic                           host_busy,
    // Channel control
    input  logic                           key_on,
    input  logic                           key_off,
    input  adpcm_pkg::ch_t                 key_ch,
    input  adpcm_pkg::addr_t               key_start,
    input  adpcm_pkg::addr_t               key_end,
    output logic [`ADPCM_NUM_CH-1:0]       ch_active,
    // Decoded output, one slot per cen
    output logic signed [`ADPCM_PCM_W-1:0] pcm,
    output adpcm_pkg::ch_t                 pcm_ch
);

    mem_bus_if seq_bus ();
    mem_bus_if host_bus ();

    logic             ram_en;
    logic             ram_we;
    adpcm_pkg::addr_t ram_addr;
    logic [7:0]       ram_wdata;
    logic [7:0]       ram_rdata;
    logic [3:0]       dec_data;
    logic             dec_chon;

    sample_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .seq       (seq_bus.arbiter),
        .host      (host_bus.arbiter),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    host_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_busy  (host_busy),
        .bus        (host_bus.master)
    );

    channel_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .key_on    (key_on),
        .key_off   (key_off),
        .key_ch    (key_ch),
        .key_start (key_start),
        .key_end   (key_end),
        .ch_active (ch_active),
        .bus       (seq_bus.master),
        .data      (dec_data),
        .chon      (dec_chon),
        .pcm_ch    (pcm_ch)
    );

    adpcm_decode u_dec (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .data  (dec_data),
        .chon  (dec_chon),
        .pcm   (pcm)
    );

endmodule

// ==== logic/channel_sequencer.sv ====
`timescale 1ns/1ps
`include "adpcm_defs.svh"

module channel_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,       // Slot advance strobe
    input  logic                     key_on,
    input  logic                     key_off,
    input  adpcm_pkg::ch_t           key_ch,
    input  adpcm_pkg::addr_t         key_start,
    input  adpcm_pkg::addr_t         key_end,
    output logic [`ADPCM_NUM_CH-1:0] ch_active,
    mem_bus_if.master                bus,
    output logic [3:0]               data,      // Nibble of the current slot
    output logic                     chon,
    output adpcm_pkg::ch_t           pcm_ch     // Slot shown on pcm
);

    import adpcm_pkg::*;

    localparam int  NUM_CH  = `ADPCM_NUM_CH;
    localparam ch_t LAST_CH = ch_t'(NUM_CH - 1);

    ch_t               slot;      // Slot presented at the next cen
    ch_t               fetch_ch;  // Channel the fetch in flight belongs to
    fetch_state_e      fstate;
    logic [NUM_CH-1:0] active;
    logic [NUM_CH-1:0] phase;     // Set when the low nibble is next
    logic [NUM_CH-1:0] loaded;    // Byte buffer holds the current byte
    addr_t             cur_addr [NUM_CH];
    addr_t             end_addr [NUM_CH];
    logic [7:0]        byte_buf [NUM_CH];
    logic              need_fetch;
    logic              consume;
    logic              at_end;

    // Current slot wants a new byte before its turn
    assign need_fetch = active[slot] & ~phase[slot] & ~loaded[slot];

    // Slot output, a slot without its byte presents chon low
    assign chon = active[slot] & loaded[slot];
    assign data = phase[slot] ? byte_buf[slot][3:0] : byte_buf[slot][7:4];

    assign consume = cen & chon;
    assign at_end  = (cur_addr[slot] == end_addr[slot]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= '0;
            pcm_ch   <= LAST_CH; // First cen shows slot 0
            fstate   <= FETCH_IDLE;
            fetch_ch <= '0;
            active   <= '0;
            phase    <= '0;
            loaded   <= '0;
        end else begin
            if (cen) begin
                pcm_ch <= slot;
                slot   <= (slot == LAST_CH) ? ch_t'(0) : ch_t'(slot + 1'b1);
            end
            // Nibble handed to the decoder
            if (consume) begin
                if (!phase[slot]) begin
                    phase[slot] <= 1'b1;
                end else begin
                    phase[slot]  <= 1'b0;
                    loaded[slot] <= 1'b0;
                    if (at_end) active[slot] <= 1'b0; // Last nibble played
                end
            end
            case (fstate)
                FETCH_IDLE: begin
                    if (need_fetch) begin
                        fetch_ch <= slot;
                        fstate   <= FETCH_REQ;
                    end
                end
                FETCH_REQ: if (bus.gnt) fstate <= FETCH_WAIT;
                FETCH_WAIT: begin
                    loaded[fetch_ch] <= 1'b1; // rdata captured below
                    fstate           <= FETCH_IDLE;
                end
                default: fstate <= FETCH_IDLE;
            endcase
            // Key control overrides slot updates on the same channel
            if (key_off) active[key_ch] <= 1'b0;
            if (key_on) begin
                active[key_ch] <= 1'b1;
                phase[key_ch]  <= 1'b0; // High nibble first
                loaded[key_ch] <= 1'b0;
            end
        end
    end

    // Addresses and byte buffers
    always_ff @(posedge clk) begin
        if (fstate == FETCH_WAIT) byte_buf[fetch_ch] <= bus.rdata;
        if (consume && phase[slot] && !at_end) cur_addr[slot] <= cur_addr[slot] + 1'b1;
        if (key_on) begin
            cur_addr[key_ch] <= key_start;
            end_addr[key_ch] <= key_end;
        end
    end

    assign bus.req   = (fstate == FETCH_REQ);
    assign bus.we    = 1'b0;               // Read-only master
    assign bus.addr  = cur_addr[fetch_ch];
    assign bus.wdata = 8'h00;

    assign ch_active = active;

endmodule

// ==== logic/host_loader.sv ====
`timescale 1ns/1ps

module host_loader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             host_we,    // One-cycle write strobe
    input  adpcm_pkg::addr_t host_addr,
    input  logic [7:0]       host_wdata,
    output logic             host_busy,  // High while a write is pending
    mem_bus_if.master        bus
);

    import adpcm_pkg::*;

    addr_t      pend_addr;
    logic [7:0] pend_data;
    logic       accept;

    assign accept = host_we & ~host_busy; // Strobes while busy are dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_busy <= 1'b0;
        end else if (accept) begin
            host_busy <= 1'b1;
        end else if (host_busy && bus.gnt) begin
            host_busy <= 1'b0; // Write done at the grant edge
        end
    end

    // Pending byte, only loaded on an accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr <= host_addr;
            pend_data <= host_wdata;
        end
    end

    assign bus.req   = host_busy;
    assign bus.we    = 1'b1;      // Host only writes
    assign bus.addr  = pend_addr;
    assign bus.wdata = pend_data;

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    mem_bus_if.arbiter       seq,
    mem_bus_if.arbiter       host,
    output logic             ram_en,
    output logic             ram_we,
    output adpcm_pkg::addr_t ram_addr,
    output logic [7:0]       ram_wdata,
    input  logic [7:0]       ram_rdata
);

    import adpcm_pkg::*;

    arb_owner_e owner;   // Owner this cycle
    arb_owner_e owner_q; // Owner last cycle, steers read data

    // Fixed priority, sequencer first so playback never stalls
    always_comb begin
        if (seq.req) owner = OWNER_SEQ;
        else if (host.req) owner = OWNER_HOST;
        else owner = OWNER_NONE;
    end

    assign seq.gnt  = (owner == OWNER_SEQ);
    assign host.gnt = (owner == OWNER_HOST);

    // Forward the granted master to the RAM
    always_comb begin
        ram_en    = (owner != OWNER_NONE);
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        case (owner)
            OWNER_SEQ: begin
                ram_we    = seq.we;
                ram_addr  = seq.addr;
                ram_wdata = seq.wdata;
            end
            OWNER_HOST: begin
                ram_we    = host.we;
                ram_addr  = host.addr;
                ram_wdata = host.wdata;
            end
            default: ram_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) owner_q <= OWNER_NONE;
        else owner_q <= owner;
    end

    // Read data only back to whoever issued the read
    assign seq.rdata  = (owner_q == OWNER_SEQ)  ? ram_rdata : 8'h00;
    assign host.rdata = (owner_q == OWNER_HOST) ? ram_rdata : 8'h00;

endmodule

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps

// One master's port to the shared sample RAM
interface mem_bus_if;

    logic               req;   // Held until gnt seen at a rising edge
    logic               gnt;   // Combinational grant from the arbiter
    logic               we;
    adpcm_pkg::addr_t   addr;
    logic [7:0]         wdata;
    logic [7:0]         rdata; // Valid the cycle after a read grant

    modport master (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// ==== logic/sample_ram.sv ====
`timescale 1ns/1ps
`include "adpcm_defs.svh"

module sample_ram (
    input  logic             clk,
    input  logic             en,
    input  logic             we,
    input  adpcm_pkg::addr_t addr,
    input  logic [7:0]       wdata,
    output logic [7:0]       rdata
);

    localparam int DEPTH = 1 << `ADPCM_ADDR_W;

    logic [7:0] mem [DEPTH]; // Two ADPCM nibbles per byte, high first

    // Single port, write or registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) mem[addr] <= wdata;
            else rdata <= mem[addr]; // Read data one cycle after the address
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the ADPCM playback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module adpcm_tb -f src.f -o adpcm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/adpcm_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== src.f ====
+incdir+include
logic/adpcm_pkg.sv
logic/mem_bus_if.sv
logic/sample_ram.sv
logic/mem_arbiter.sv
logic/host_loader.sv
logic/channel_sequencer.sv
logic/adpcm_decode.sv
logic/adpcm_top.sv
dv/adpcm_assertions.sv
dv/adpcm_tb.sv
